// File: rtl/dma_counter.sv
`timescale 1ns/1ns

module dma_counter import sdmac_reg_pkg::*, sdmac_dma_pkg::*; (
    input  logic CLK,
    input  logic _AS,          // System reset
    input  logic st_dma,       // Start pulse
    input  logic sp_dma,       // Abort pulse
    input  wtc_t wtc,          // Words to move
    input  logic word_valid,   // One word finished
    output logic dma_run,
    output logic tc            // Terminal count pulse
);

    dma_state_e state;
    wtc_t       remain;    // Words still to come
    logic       last;      // Final word seen

    assign dma_run = (state == DMA_RUN);
    assign last    = word_valid && (remain == wtc_t'(1));

    always_ff @(posedge CLK or posedge _AS) begin
        if (_AS) begin
            state  <= DMA_IDLE;
            remain <= '0;
            tc     <= 1'b0;
        end else begin
            tc <= 1'b0;
            case (state)
                DMA_IDLE: begin
                    // Zero count never starts
                    if (st_dma && (wtc != '0)) begin
                        remain <= wtc;
                        state  <= DMA_RUN;
                    end
                end
                DMA_RUN: begin
                    if (sp_dma) begin
                        state <= DMA_IDLE;  // Abort, no tc
                    end else if (word_valid) begin
                        remain <= remain - wtc_t'(1);
                        if (last) begin
                            state <= DMA_IDLE;
                            tc    <= 1'b1;
                        end
                    end
                end
                default: state <= DMA_IDLE;
            endcase
        end
    end

endmodule

// File: rtl/int_status.sv
`timescale 1ns/1ns

module int_status import sdmac_reg_pkg::*; (
    input  logic  CLK,
    input  logic  _AS,         // System reset
    input  logic  tc,          // End of transfer pulse
    input  logic  scsi_int,    // Level from SCSI chip
    input  logic  clr_int,     // Clear strobe
    input  logic  buf_empty,
    input  logic  dma_run,
    input  logic  int_en,      // CNTR enable bit
    output istr_t istr,
    output logic  irq
);

    logic e_int;     // Sticky end of transfer
    logic ints;      // Sticky SCSI interrupt
    logic pending;

    assign pending = e_int || ints;

    // Set beats clear
    always_ff @(posedge CLK or posedge _AS) begin
        if (_AS) begin
            e_int <= 1'b0;
            ints  <= 1'b0;
            irq   <= 1'b0;
        end else begin
            e_int <= tc || (e_int && !clr_int);
            ints  <= scsi_int || (ints && !clr_int);
            irq   <= pending && int_en;
        end
    end

    // Status word
    always_comb begin
        istr               = '0;
        istr[ISTR_INT_P]   = pending;
        istr[ISTR_INTS]    = ints;
        istr[ISTR_E_INT]   = e_int;
        istr[ISTR_FE]      = buf_empty;  // Live
        istr[ISTR_DMA_ACT] = dma_run;    // Live
    end

endmodule

// File: rtl/scsi_pack.sv
`timescale 1ns/1ns

module scsi_pack import sdmac_dma_pkg::*; (
    input  logic       CLK,
    input  logic       _AS,         // System reset
    input  scsi_byte_t scsi_data,
    input  logic       scsi_drq,    // One pulse per byte
    input  logic       dma_run,     // Bytes only taken while running
    input  logic       flush,       // Push out a partial word
    output dma_word_t  word,
    output logic       word_valid,
    output logic       buf_empty
);

    dma_word_t sr;        // Byte shifter, newest byte at the bottom
    byte_cnt_t cnt;       // Bytes held
    logic      take;      // Byte accepted this edge
    logic      do_flush;  // Flush with something to send
    logic      full;      // Fourth byte arriving
    dma_word_t part;      // Held bytes moved to the top

    assign take     = scsi_drq && dma_run;
    assign do_flush = flush && (cnt != 2'd0);
    assign full     = take && (cnt == 2'd3);
    assign buf_empty = (cnt == 2'd0);

    // Left align the held bytes, zeros below
    always_comb begin
        case (cnt)
            2'd1:    part = {sr[7:0], 24'h0};
            2'd2:    part = {sr[15:0], 16'h0};
            2'd3:    part = {sr[23:0], 8'h0};
            default: part = '0;
        endcase
    end

    // Count and word strobe
    always_ff @(posedge CLK or posedge _AS) begin
        if (_AS) begin
            cnt        <= '0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= do_flush || full;
            if (do_flush) begin
                // A byte on the same edge opens the next word
                cnt <= take ? 2'd1 : 2'd0;
            end else if (take) begin
                cnt <= cnt + 2'd1;  // Wraps to 0 on the fourth
            end
        end
    end

    // Data path
    always_ff @(posedge CLK) begin
        if (take) begin
            sr <= {sr[23:0], scsi_data};  // First byte ends up on top
        end
        if (do_flush) begin
            word <= part;
        end else if (full) begin
            word <= {sr[23:0], scsi_data};  // Big endian
        end
    end

endmodule

// File: rtl/sdmac_dma_pkg.sv
package sdmac_dma_pkg;

    // SCSI side data
    typedef logic [7:0] scsi_byte_t;

    // Word handed to the memory side
    typedef logic [31:0] dma_word_t;

    // Bytes waiting in the pack buffer, 0 to 3
    typedef logic [1:0] byte_cnt_t;

    // Transfer control
    typedef enum logic {
        DMA_IDLE = 1'b0,  // No transfer
        DMA_RUN  = 1'b1   // Words being counted
    } dma_state_e;

endpackage

// File: rtl/sdmac_reg_pkg.sv
package sdmac_reg_pkg;

    // CPU side widths
    typedef logic [4:0]  reg_addr_t;   // Longword index, CPU addr[6:2]
    typedef logic [31:0] bus_data_t;   // CPU data bus
    typedef logic [1:0]  dawr_t;       // Acknowledge width code
    typedef logic [23:0] wtc_t;        // Word transfer count
    typedef logic [5:0]  cntr_t;       // Control register
    typedef logic [8:0]  istr_t;       // Interrupt status

    // Register map, byte offset is index * 4
    localparam reg_addr_t REG_DAWR   = 5'h00;  // Write only
    localparam reg_addr_t REG_WTC    = 5'h01;
    localparam reg_addr_t REG_CNTR   = 5'h02;
    localparam reg_addr_t REG_ST_DMA = 5'h04;  // Strobe
    localparam reg_addr_t REG_FLUSH  = 5'h05;  // Strobe
    localparam reg_addr_t REG_CINT   = 5'h06;  // Strobe
    localparam reg_addr_t REG_ISTR   = 5'h07;  // Read only
    localparam reg_addr_t REG_SP_DMA = 5'h0f;  // Strobe

    // CNTR bits
    localparam int CNTR_INTEN = 2;  // Interrupt enable

    // ISTR bits, the rest read as zero
    localparam int ISTR_INT_P   = 8;  // Any interrupt pending
    localparam int ISTR_INTS    = 7;  // SCSI chip interrupt seen
    localparam int ISTR_E_INT   = 6;  // End of transfer
    localparam int ISTR_FE      = 1;  // Pack buffer empty
    localparam int ISTR_DMA_ACT = 0;  // Transfer running

endpackage

// File: rtl/sdmac_registers.sv
`timescale 1ns/1ns

module sdmac_registers import sdmac_reg_pkg::*; (
    input  logic      CLK,
    input  logic      _AS,      // System reset
    input  logic      sel,      // Chip select
    input  logic      ds,       // Data strobe
    input  logic      rw,       // High for read
    input  reg_addr_t addr,     // CPU addr[6:2]
    input  bus_data_t din,
    input  istr_t     istr,     // Live status from int_status
    output bus_data_t dout,
    output logic [1:0] dsack,
    output wtc_t      wtc,
    output logic      int_en,
    output logic      st_dma,
    output logic      flush,
    output logic      clr_int,
    output logic      sp_dma
);

    dawr_t     dawr;      // Acknowledge width, write only
    cntr_t     cntr;
    logic      busy;      // Inside a bus cycle
    logic      start;     // First edge of a cycle
    bus_data_t rd_data;

    // DAWR to dsack encoding
    function automatic logic [1:0] dsack_code(input dawr_t width);
        case (width)
            2'd1:    dsack_code = 2'b01;  // Byte port
            2'd2:    dsack_code = 2'b10;  // Word port
            default: dsack_code = 2'b11;  // Longword
        endcase
    endfunction

    // A cycle begins once per ds assertion
    assign start  = sel && ds && !busy;
    assign int_en = cntr[CNTR_INTEN];

    // Read mux, zero extended
    always_comb begin
        rd_data = '0;
        case (addr)
            REG_WTC:  rd_data = bus_data_t'(wtc);
            REG_CNTR: rd_data = bus_data_t'(cntr);
            REG_ISTR: rd_data = bus_data_t'(istr);   // Sampled at the start edge
            default:  rd_data = '0;                  // DAWR, strobes, unmapped
        endcase
    end

    // Cycle tracking and acknowledge
    always_ff @(posedge CLK or posedge _AS) begin
        if (_AS) begin
            busy  <= 1'b0;
            dsack <= 2'b00;
        end else if (start) begin
            busy  <= 1'b1;
            dsack <= dsack_code(dawr);  // Width in force before this access
        end else if (busy && !ds) begin
            // CPU has let go of ds
            busy  <= 1'b0;
            dsack <= 2'b00;
        end
    end

    // Stored registers and read data
    always_ff @(posedge CLK or posedge _AS) begin
        if (_AS) begin
            dawr <= '0;
            wtc  <= '0;
            cntr <= '0;
            dout <= '0;
        end else if (start) begin
            if (rw) begin
                dout <= rd_data;
            end else begin
                case (addr)
                    REG_DAWR: dawr <= dawr_t'(din);  // Upper bits dropped
                    REG_WTC:  wtc  <= wtc_t'(din);
                    REG_CNTR: cntr <= cntr_t'(din);
                    default:  ;                       // ISTR is read only
                endcase
            end
        end
    end

    // Strobe addresses, direction ignored
    always_ff @(posedge CLK or posedge _AS) begin
        if (_AS) begin
            st_dma  <= 1'b0;
            flush   <= 1'b0;
            clr_int <= 1'b0;
            sp_dma  <= 1'b0;
        end else begin
            st_dma  <= start && (addr == REG_ST_DMA);
            flush   <= start && (addr == REG_FLUSH);
            clr_int <= start && (addr == REG_CINT);
            sp_dma  <= start && (addr == REG_SP_DMA);  // One cycle each
        end
    end

endmodule

// File: rtl/sdmac_top.sv
`timescale 1ns/1ns

module sdmac_top import sdmac_reg_pkg::*, sdmac_dma_pkg::*; (
    input  logic       CLK,
    input  logic       _AS,          // System reset
    // CPU bus
    input  logic       sel,
    input  logic       ds,
    input  logic       rw,
    input  reg_addr_t  addr,
    input  bus_data_t  din,
    output bus_data_t  dout,
    output logic [1:0] dsack,
    // SCSI chip
    input  scsi_byte_t scsi_data,
    input  logic       scsi_drq,
    input  logic       scsi_int,
    // Memory side, no back-pressure
    output dma_word_t  word,
    output logic       word_valid,
    output logic       irq
);

    wtc_t  wtc;
    logic  int_en;
    logic  st_dma;
    logic  flush;
    logic  clr_int;
    logic  sp_dma;
    logic  dma_run;
    logic  tc;
    logic  buf_empty;
    istr_t istr;

    // CPU register slave
    sdmac_registers i_registers (
        .CLK    (CLK),
        ._AS    (_AS),
        .sel    (sel),
        .ds     (ds),
        .rw     (rw),
        .addr   (addr),
        .din    (din),
        .istr   (istr),
        .dout   (dout),
        .dsack  (dsack),
        .wtc    (wtc),
        .int_en (int_en),
        .st_dma (st_dma),
        .flush  (flush),
        .clr_int(clr_int),
        .sp_dma (sp_dma)
    );

    // Byte to word packer
    scsi_pack i_pack (
        .CLK       (CLK),
        ._AS       (_AS),
        .scsi_data (scsi_data),
        .scsi_drq  (scsi_drq),
        .dma_run   (dma_run),
        .flush     (flush),
        .word      (word),
        .word_valid(word_valid),
        .buf_empty (buf_empty)
    );

    dma_counter i_counter (
        .CLK       (CLK),
        ._AS       (_AS),
        .st_dma    (st_dma),
        .sp_dma    (sp_dma),
        .wtc       (wtc),
        .word_valid(word_valid),
        .dma_run   (dma_run),
        .tc        (tc)
    );

    int_status i_int (
        .CLK      (CLK),
        ._AS      (_AS),
        .tc       (tc),
        .scsi_int (scsi_int),
        .clr_int  (clr_int),
        .buf_empty(buf_empty),
        .dma_run  (dma_run),
        .int_en   (int_en),
        .istr     (istr),
        .irq      (irq)
    );

endmodule

// File: sim.f
rtl/sdmac_reg_pkg.sv
rtl/sdmac_dma_pkg.sv
rtl/sdmac_registers.sv
rtl/scsi_pack.sv
rtl/dma_counter.sv
rtl/int_status.sv
rtl/sdmac_top.sv
test/tb_sdmac.sv

// File: test/tb_sdmac.sv
`timescale 1ns/1ns

module tb_sdmac
    import sdmac_reg_pkg::*, sdmac_dma_pkg::*;
();

    // Row operations of the stimulus table
    typedef enum {OP_WR, OP_RD, OP_BYTES, OP_INT, OP_IRQ, OP_WORDS} op_e;

    logic       CLK;
    logic       _AS;
    logic       sel;
    logic       ds;
    logic       rw;
    reg_addr_t  addr;
    bus_data_t  din;
    bus_data_t  dout;
    logic [1:0] dsack;
    scsi_byte_t scsi_data;
    logic       scsi_drq;
    logic       scsi_int;
    dma_word_t  word;
    logic       word_valid;
    logic       irq;

    // Table columns, one entry per row
    op_e       row_op[$];
    reg_addr_t row_addr[$];
    bus_data_t row_data[$];   // Write data, expected read data, count or level

    // Reference model of the transfer side
    dawr_t       mdl_dawr;
    wtc_t        mdl_wtc;
    wtc_t        mdl_left;
    logic        mdl_run;
    int          held;        // Bytes waiting in the pack buffer
    dma_word_t   acc;         // Newest byte at the bottom
    dma_word_t   exp_words[$];
    logic [31:0] rng;

    int err_cnt;
    int timeout_cnt;

    sdmac_top i_sdmac_top (
        .CLK       (CLK),
        ._AS       (_AS),
        .sel       (sel),
        .ds        (ds),
        .rw        (rw),
        .addr      (addr),
        .din       (din),
        .dout      (dout),
        .dsack     (dsack),
        .scsi_data (scsi_data),
        .scsi_drq  (scsi_drq),
        .scsi_int  (scsi_int),
        .word      (word),
        .word_valid(word_valid),
        .irq       (irq)
    );

    always #10 CLK = ~CLK;  // 20 ns period

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Acknowledge width table
    function automatic logic [1:0] expected_dsack(input dawr_t w);
        case (w)
            2'd1:    return 2'b01;
            2'd2:    return 2'b10;
            default: return 2'b11;  // 0 and 3 both longword
        endcase
    endfunction

    task automatic add_row(input op_e op, input reg_addr_t a, input bus_data_t d);
        row_op.push_back(op);
        row_addr.push_back(a);
        row_data.push_back(d);
    endtask

    // One word leaves the packer, counts against WTC while running
    task automatic word_done();
        if (mdl_run) begin
            mdl_left = mdl_left - 1;
            if (mdl_left == 0) begin
                mdl_run = 1'b0;
            end
        end
    endtask

    task automatic model_byte(input scsi_byte_t b);
        if (mdl_run) begin
            acc  = {acc[23:0], b};
            held = held + 1;
            if (held == 4) begin
                exp_words.push_back(acc);  // First byte on top
                held = 0;
                word_done();
            end
        end
    endtask

    // Side effects of a bus access
    task automatic model_access(input logic read, input reg_addr_t a, input bus_data_t d);
        if (a == REG_ST_DMA && !mdl_run && mdl_wtc != 0) begin
            mdl_run  = 1'b1;
            mdl_left = mdl_wtc;
        end
        if (a == REG_SP_DMA) begin
            mdl_run = 1'b0;
        end
        if (a == REG_FLUSH && held > 0) begin
            exp_words.push_back(acc << (8 * (4 - held)));  // Zero padded low bytes
            held = 0;
            word_done();
        end
        if (!read && a == REG_WTC) begin
            mdl_wtc = d[23:0];
        end
        if (!read && a == REG_DAWR) begin
            mdl_dawr = d[1:0];  // Applies from the next cycle
        end
    endtask

    task automatic bus_cycle(input logic read, input reg_addr_t a, input bus_data_t d,
                             output bus_data_t q);
        int         t;
        logic [1:0] want;
        want = expected_dsack(mdl_dawr);
        model_access(read, a, d);  // Expected word queued before the flush pulse
        sel  = 1'b1;
        ds   = 1'b1;
        rw   = read;
        addr = a;
        din  = read ? '0 : d;
        t    = 0;
        @(negedge CLK);
        while (dsack == 2'b00 && t < 20) begin
            @(negedge CLK);
            t++;
        end
        assert (dsack != 2'b00) else begin
            timeout_cnt++;
            $display("Timeout at %0t: no acknowledge for register %0d", $time, a);
        end
        if (dsack != 2'b00) begin
            assert (dsack == want) else begin
                err_cnt++;
                $display("ERROR %0t dsack got %b expected %b", $time, dsack, want);
            end
        end
        q   = dout;
        ds  = 1'b0;
        sel = 1'b0;
        t   = 0;
        @(negedge CLK);
        while (dsack != 2'b00 && t < 20) begin
            @(negedge CLK);
            t++;
        end
        assert (dsack == 2'b00) else begin
            timeout_cnt++;
            $display("Timeout at %0t: acknowledge stuck after data strobe dropped", $time);
        end
    endtask

    // One byte every other cycle so the run flag settles between bytes
    task automatic send_bytes(input int n);
        int i;
        for (i = 0; i < n; i++) begin
            rng       = xorshift32(rng);
            scsi_data = rng[7:0];
            scsi_drq  = 1'b1;
            model_byte(rng[7:0]);
            @(negedge CLK);
            scsi_drq = 1'b0;
            @(negedge CLK);
        end
        repeat (3) @(negedge CLK);  // tc then sticky flag
    endtask

    task automatic check_irq(input logic want);
        repeat (2) @(negedge CLK);  // Flag update, then registered irq
        assert (irq === want) else begin
            err_cnt++;
            $display("ERROR %0t irq got %b expected %b", $time, irq, want);
        end
    endtask

    // All expected words must have shown up
    task automatic check_words();
        int t;
        t = 0;
        while (exp_words.size() != 0 && t < 20) begin
            @(negedge CLK);
            t++;
        end
        assert (exp_words.size() == 0) else begin
            timeout_cnt++;
            $display("Timeout at %0t: %0d expected words never arrived", $time,
                     exp_words.size());
        end
    endtask

    // Word monitor, compares in arrival order
    always @(negedge CLK) begin : word_monitor
        dma_word_t want;
        if (!_AS && word_valid) begin
            assert (exp_words.size() != 0) else begin
                err_cnt++;
                $display("Unexpected word %h from the packer at %0t", word, $time);
            end
            if (exp_words.size() != 0) begin
                want = exp_words.pop_front();
                assert (word === want) else begin
                    err_cnt++;
                    $display("ERROR %0t word got %h expected %h", $time, word, want);
                end
            end
        end
    end

    initial begin
        int        i;
        bus_data_t rd;
        CLK       = 1'b0;
        _AS       = 1'b1;
        sel       = 1'b0;
        ds        = 1'b0;
        rw        = 1'b1;
        addr      = '0;
        din       = '0;
        scsi_data = '0;
        scsi_drq  = 1'b0;
        scsi_int  = 1'b0;
        mdl_dawr  = '0;
        mdl_wtc   = '0;
        mdl_left  = '0;
        mdl_run   = 1'b0;
        held      = 0;
        acc       = '0;
        rng       = 32'h589f;
        err_cnt     = 0;
        timeout_cnt = 0;

        // Reset values, masking, zero reads
        add_row(OP_RD, REG_WTC, 0);
        add_row(OP_RD, REG_CNTR, 0);
        add_row(OP_RD, REG_ISTR, 32'h002);     // Buffer empty only
        add_row(OP_RD, REG_ST_DMA, 0);         // WTC still zero
        add_row(OP_RD, REG_DAWR, 0);
        add_row(OP_RD, 5'h03, 0);              // Unmapped
        add_row(OP_RD, 5'h1f, 0);
        add_row(OP_WR, REG_WTC, 32'habcdef12);
        add_row(OP_RD, REG_WTC, 32'h00cdef12);
        add_row(OP_WR, REG_CNTR, 32'hffffffff);
        add_row(OP_RD, REG_CNTR, 32'h3f);
        add_row(OP_IRQ, '0, 0);                // Enabled but nothing pending
        add_row(OP_RD, REG_FLUSH, 0);
        add_row(OP_RD, REG_CINT, 0);
        add_row(OP_RD, REG_SP_DMA, 0);
        // Acknowledge widths
        add_row(OP_WR, REG_DAWR, 1);
        add_row(OP_RD, REG_CNTR, 32'h3f);
        add_row(OP_WR, REG_DAWR, 2);
        add_row(OP_RD, REG_WTC, 32'h00cdef12);
        add_row(OP_WR, REG_DAWR, 3);
        add_row(OP_RD, REG_ISTR, 32'h002);
        add_row(OP_RD, REG_DAWR, 0);           // Write only, holds 3 here
        add_row(OP_WR, REG_DAWR, 0);
        // Three words to terminal count
        add_row(OP_WR, REG_CNTR, 0);
        add_row(OP_WR, REG_WTC, 3);
        add_row(OP_WR, REG_ST_DMA, 0);
        add_row(OP_RD, REG_ISTR, 32'h003);
        add_row(OP_BYTES, '0, 12);
        add_row(OP_RD, REG_ISTR, 32'h142);     // End of transfer, pending
        add_row(OP_BYTES, '0, 4);              // Ignored, not running
        add_row(OP_WORDS, '0, 0);
        add_row(OP_IRQ, '0, 0);
        add_row(OP_WR, REG_CNTR, 32'h4);
        add_row(OP_IRQ, '0, 1);
        add_row(OP_WR, REG_CINT, 0);
        add_row(OP_IRQ, '0, 0);
        add_row(OP_RD, REG_ISTR, 32'h002);
        // Partial word by flush
        add_row(OP_WR, REG_WTC, 5);
        add_row(OP_WR, REG_ST_DMA, 0);
        add_row(OP_BYTES, '0, 2);
        add_row(OP_RD, REG_ISTR, 32'h001);     // Running, buffer holds bytes
        add_row(OP_WR, REG_FLUSH, 0);
        add_row(OP_WORDS, '0, 0);
        add_row(OP_RD, REG_ISTR, 32'h003);
        // SCSI interrupt, enable, clear, stop
        add_row(OP_INT, '0, 1);
        add_row(OP_RD, REG_ISTR, 32'h183);
        add_row(OP_IRQ, '0, 1);
        add_row(OP_WR, REG_CNTR, 0);
        add_row(OP_IRQ, '0, 0);
        add_row(OP_INT, '0, 0);
        add_row(OP_RD, REG_ISTR, 32'h183);     // Sticky
        add_row(OP_WR, REG_CINT, 0);
        add_row(OP_RD, REG_ISTR, 32'h003);
        add_row(OP_WR, REG_CNTR, 32'h4);
        add_row(OP_IRQ, '0, 0);
        add_row(OP_WR, REG_SP_DMA, 0);
        add_row(OP_IRQ, '0, 0);                // Room for a stray end of transfer
        add_row(OP_RD, REG_ISTR, 32'h002);     // No end of transfer on abort
        add_row(OP_BYTES, '0, 4);
        add_row(OP_WORDS, '0, 0);

        repeat (10) @(negedge CLK);
        _AS = 1'b0;
        @(negedge CLK);

        for (i = 0; i < row_op.size(); i++) begin
            case (row_op[i])
                OP_WR:    bus_cycle(1'b0, row_addr[i], row_data[i], rd);
                OP_RD: begin
                    bus_cycle(1'b1, row_addr[i], '0, rd);
                    assert (rd === row_data[i]) else begin
                        err_cnt++;
                        $display("ERROR %0t dout reg %0d got %h expected %h", $time,
                                 row_addr[i], rd, row_data[i]);
                    end
                end
                OP_BYTES: send_bytes(int'(row_data[i]));
                OP_INT: begin
                    scsi_int = row_data[i][0];
                    repeat (2) @(negedge CLK);
                end
                OP_IRQ:   check_irq(row_data[i][0]);
                OP_WORDS: check_words();
                default:  ;
            endcase
        end

        repeat (4) @(negedge CLK);
        $display("Summary: %0d errors, %0d timeouts", err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
